// File: source/dlc_cfg_pkg.sv
/*
  Register map and configuration field types of the level-crossing encoder.
  Imported by the register file, the encoder and the top level.
*/
package dlc_cfg_pkg;

  // Register port geometry
  localparam int REG_ADDR_W = 4;
  localparam int REG_DATA_W = 16;

  // Word addresses
  localparam logic [REG_ADDR_W-1:0] ADDR_LOG_WL    = 4'd0;  // log2 of level width
  localparam logic [REG_ADDR_W-1:0] ADDR_DLVL_BITS = 4'd1;  // Delta-level field size
  localparam logic [REG_ADDR_W-1:0] ADDR_DLVL_FMT  = 4'd2;  // 1 = two's complement
  localparam logic [REG_ADDR_W-1:0] ADDR_DT_MASK   = 4'd3;  // Delta-time saturation mask

  // Field types
  typedef logic [3:0] log_wl_t;     // Arithmetic shift amount on samples
  typedef logic [3:0] dlvl_bits_t;  // Number of delta-level bits in a packet

  // Reset values
  localparam log_wl_t                 LOG_WL_RST    = 4'd0;
  localparam dlvl_bits_t              DLVL_BITS_RST = 4'd4;
  localparam logic                    DLVL_FMT_RST  = 1'b0;  // Sign-magnitude
  localparam logic [REG_DATA_W-1:0]   DT_MASK_RST   = 16'h00FF;

  // The delta-level mask is derived in the encoder from DLVL_BITS

endpackage

// File: source/dlc_data_pkg.sv
/*
  Sample, level and packet types plus FIFO sizing and the encoder state type.
*/
package dlc_data_pkg;

  localparam int SAMPLE_W = 16;

  typedef logic signed [SAMPLE_W-1:0] sample_t;  // Raw input sample
  typedef logic signed [15:0]         level_t;   // Sample after level quantization
  typedef logic [15:0]                packet_t;  // Encoded output word

  // FIFO sizing, shared by input and output FIFOs
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Encoder FSM
  typedef enum logic [1:0] {
    DLC_RUN,       // Consume samples, push fitting crossings
    DLC_DLVL_OVF,  // Emit chunks of an oversized delta-level
    DLC_DT_OVF     // Emit one filler packet for a saturated delta-time
  } dlc_state_t;

endpackage

// File: source/dlc_fifo.sv
/*
  Synchronous circular-buffer FIFO, not fall-through; payload set by type parameter.
  Pushes while full and pops while empty are ignored.
*/
`timescale 1ns/1ps

module dlc_fifo
  import dlc_data_pkg::*;
#(
  parameter type payload_t = sample_t
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  payload_t                mem [FIFO_DEPTH];  // Storage, no reset
  logic [FIFO_PTR_W-1:0]   wr_ptr_q;
  logic [FIFO_PTR_W-1:0]   rd_ptr_q;
  logic [FIFO_CNT_W-1:0]   cnt_q;             // Entries held
  logic                    push_ok;
  logic                    pop_ok;

  assign push_ok = push_i && !full_o;   // Drop push when full
  assign pop_ok  = pop_i && !empty_o;   // Ignore pop when empty

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin  // Wrap at depth
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push_ok && !pop_ok) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign data_o  = mem[rd_ptr_q];                        // Head entry
  assign full_o  = (cnt_q == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty_o = (cnt_q == '0);

endmodule

// File: source/dlc_regs.sv
/*
  Configuration registers of the encoder behind a single-cycle register port.
  Writes land on the clock edge; reads are combinational from the address.
*/
`timescale 1ns/1ps

module dlc_regs
  import dlc_cfg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Register port
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [REG_DATA_W-1:0] reg_wdata_i,
  output logic [REG_DATA_W-1:0] reg_rdata_o,
  // Configuration towards the encoder
  output log_wl_t               cfg_log_wl_o,
  output dlvl_bits_t            cfg_dlvl_bits_o,
  output logic                  cfg_twos_comp_o,
  output logic [15:0]           cfg_dt_mask_o
);

  log_wl_t                 log_wl_q;
  dlvl_bits_t              dlvl_bits_q;
  logic                    twos_comp_q;   // 0 = sign-magnitude
  logic [REG_DATA_W-1:0]   dt_mask_q;
  logic                    wr_en;

  assign wr_en = reg_valid_i && reg_write_i;

  // Write decode, unmapped addresses ignored
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      log_wl_q    <= LOG_WL_RST;
      dlvl_bits_q <= DLVL_BITS_RST;
      twos_comp_q <= DLVL_FMT_RST;
      dt_mask_q   <= DT_MASK_RST;
    end else if (wr_en) begin
      case (reg_addr_i)
        ADDR_LOG_WL:    log_wl_q    <= reg_wdata_i[$bits(log_wl_t)-1:0];
        ADDR_DLVL_BITS: dlvl_bits_q <= reg_wdata_i[$bits(dlvl_bits_t)-1:0];
        ADDR_DLVL_FMT:  twos_comp_q <= reg_wdata_i[0];
        ADDR_DT_MASK:   dt_mask_q   <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  // Read mux, narrow fields zero-extended
  always_comb begin
    case (reg_addr_i)
      ADDR_LOG_WL:    reg_rdata_o = REG_DATA_W'(log_wl_q);
      ADDR_DLVL_BITS: reg_rdata_o = REG_DATA_W'(dlvl_bits_q);
      ADDR_DLVL_FMT:  reg_rdata_o = REG_DATA_W'(twos_comp_q);
      ADDR_DT_MASK:   reg_rdata_o = dt_mask_q;
      default:        reg_rdata_o = '0;  // Unmapped reads zero
    endcase
  end

  assign cfg_log_wl_o    = log_wl_q;
  assign cfg_dlvl_bits_o = dlvl_bits_q;
  assign cfg_twos_comp_o = twos_comp_q;
  assign cfg_dt_mask_o   = dt_mask_q;

endmodule

// File: source/dlc_encoder.sv
/*
  Level-crossing encoder core: pops samples, tracks level and delta-time,
  splits oversized delta-levels and emits fillers on delta-time saturation.
*/
`timescale 1ns/1ps

module dlc_encoder
  import dlc_cfg_pkg::*;
  import dlc_data_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Input FIFO side
  input  sample_t     sample_i,
  input  logic        sample_empty_i,
  output logic        sample_pop_o,
  // Output FIFO side
  input  logic        pkt_full_i,
  output logic        pkt_push_o,
  output packet_t     pkt_o,
  // Configuration
  input  log_wl_t     cfg_log_wl_i,
  input  dlvl_bits_t  cfg_dlvl_bits_i,
  input  logic        cfg_twos_comp_i,
  input  logic [15:0] cfg_dt_mask_i
);

  dlc_state_t         state_q, state_d;
  level_t             curr_lvl_q;      // Level of last crossing
  level_t             din_lvl;         // Level of head sample
  logic [15:0]        dt_cnt_q;        // Samples since last packet
  logic [15:0]        ovf_cnt_q;       // Magnitude left to send while splitting
  logic               dir_q;           // Held direction of a split, 1 = down
  logic [15:0]        dlvl_mask;
  logic signed [16:0] sub_a, sub_b;
  logic signed [16:0] sub_res;         // Shared subtractor result
  logic signed [16:0] sub_neg;
  logic               dir;
  logic [15:0]        dlvl_abs;
  logic               xing;            // Head sample changes level
  logic               fits;            // Delta-level fits its field
  logic               last_chunk;      // Remainder at most one mask
  logic [15:0]        dt_out;
  logic [15:0]        dlvl_out;
  logic               dir_out;
  logic [16:0]        upper;           // Fields above the delta-level
  logic [16:0]        pkt_wide;

  // All ones over the configured delta-level width
  assign dlvl_mask = ~(16'hFFFF << cfg_dlvl_bits_i);

  assign din_lvl = sample_i >>> cfg_log_wl_i;  // Arithmetic, keeps sign

  // Pop only in RUN with room downstream
  assign sample_pop_o = (state_q == DLC_RUN) && !sample_empty_i && !pkt_full_i;

  // One subtractor: level difference in RUN, down-count while splitting
  always_comb begin
    if (state_q == DLC_DLVL_OVF) begin
      sub_a = {1'b0, ovf_cnt_q};
      sub_b = {1'b0, dlvl_mask};
    end else if (sample_pop_o) begin
      sub_a = {din_lvl[15], din_lvl};   // Sign extend so extremes cannot wrap
      sub_b = {curr_lvl_q[15], curr_lvl_q};
    end else begin
      sub_a = '0;
      sub_b = '0;
    end
  end

  assign sub_res = sub_a - sub_b;
  assign sub_neg = -sub_res;

  assign dir        = sub_res[16];                            // Downward step
  assign dlvl_abs   = dir ? sub_neg[15:0] : sub_res[15:0];
  assign xing       = sample_pop_o && (sub_res != '0);
  assign fits       = (dlvl_abs & ~dlvl_mask) == '0;
  assign last_chunk = sub_res[16] || (sub_res == '0);         // ovf_cnt <= mask

  // Push decision
  always_comb begin
    case (state_q)
      DLC_RUN:      pkt_push_o = xing && fits;  // Pop already implies room
      DLC_DLVL_OVF: pkt_push_o = !pkt_full_i;
      DLC_DT_OVF:   pkt_push_o = !pkt_full_i;
      default:      pkt_push_o = 1'b0;
    endcase
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      DLC_RUN: begin
        if (xing && !fits) begin
          state_d = DLC_DLVL_OVF;                               // Start split
        end else if (sample_pop_o && !xing && (dt_cnt_q == cfg_dt_mask_i)) begin
          state_d = DLC_DT_OVF;                                 // Counter saturated
        end
      end
      DLC_DLVL_OVF: if (!pkt_full_i && last_chunk) state_d = DLC_RUN;
      DLC_DT_OVF:   if (!pkt_full_i) state_d = DLC_RUN;
      default:      state_d = DLC_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= DLC_RUN;
      curr_lvl_q <= '0;
      dt_cnt_q   <= '0;
      ovf_cnt_q  <= '0;
      dir_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      if (xing) begin
        curr_lvl_q <= din_lvl;  // Split crossings also move the level
      end
      // Delta-time counter
      if (state_q == DLC_RUN && sample_pop_o) begin
        if (xing && fits) begin
          dt_cnt_q <= 16'd1;
        end else if (!xing) begin
          dt_cnt_q <= dt_cnt_q + 16'd1;
        end
      end else if (state_q == DLC_DLVL_OVF && !pkt_full_i) begin
        dt_cnt_q <= last_chunk ? 16'd1 : 16'd0;  // Later chunks carry zero
      end else if (state_q == DLC_DT_OVF && !pkt_full_i) begin
        dt_cnt_q <= 16'd1;
      end
      // Split bookkeeping
      if (xing && !fits) begin
        ovf_cnt_q <= dlvl_abs;
        dir_q     <= dir;
      end else if (state_q == DLC_DLVL_OVF && !pkt_full_i && !last_chunk) begin
        ovf_cnt_q <= sub_res[15:0];
      end
    end
  end

  // Packet fields per state
  always_comb begin
    case (state_q)
      DLC_DLVL_OVF: begin
        dt_out   = dt_cnt_q;
        dlvl_out = last_chunk ? ovf_cnt_q : dlvl_mask;  // Magnitude in both formats
        dir_out  = dir_q;
      end
      DLC_DT_OVF: begin
        dt_out   = cfg_dt_mask_i;  // Filler
        dlvl_out = '0;
        dir_out  = 1'b0;
      end
      default: begin
        dt_out   = dt_cnt_q;
        dlvl_out = cfg_twos_comp_i ? sub_res[15:0] : dlvl_abs;
        dir_out  = dir;
      end
    endcase
  end

  // Two's complement: dt above field; sign-magnitude: dt, dir, magnitude
  assign upper    = cfg_twos_comp_i ? {1'b0, dt_out} : {dt_out, dir_out};
  assign pkt_wide = (upper << cfg_dlvl_bits_i) | {1'b0, dlvl_out & dlvl_mask};
  assign pkt_o    = pkt_wide[15:0];  // Truncate to packet width

endmodule

// File: source/dlc_top.sv
/*
  Level-crossing encoder top: register file, input sample FIFO, encoder and
  output packet FIFO. Host, source and sink connect through loose ports.
*/
`timescale 1ns/1ps

module dlc_top
  import dlc_cfg_pkg::*;
  import dlc_data_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Register port
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [REG_DATA_W-1:0] reg_wdata_i,
  output logic [REG_DATA_W-1:0] reg_rdata_o,
  // Sample stream in
  input  logic                  in_push_i,
  input  sample_t               in_data_i,
  output logic                  in_full_o,
  // Packet stream out
  input  logic                  out_pop_i,
  output packet_t               out_data_o,
  output logic                  out_empty_o
);

  log_wl_t     cfg_log_wl;
  dlvl_bits_t  cfg_dlvl_bits;
  logic        cfg_twos_comp;
  logic [15:0] cfg_dt_mask;
  sample_t     sample;        // Input FIFO head
  logic        sample_empty;
  logic        sample_pop;
  packet_t     pkt;
  logic        pkt_push;
  logic        pkt_full;

  dlc_regs u_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .reg_valid_i     (reg_valid_i),
    .reg_write_i     (reg_write_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_rdata_o     (reg_rdata_o),
    .cfg_log_wl_o    (cfg_log_wl),
    .cfg_dlvl_bits_o (cfg_dlvl_bits),
    .cfg_twos_comp_o (cfg_twos_comp),
    .cfg_dt_mask_o   (cfg_dt_mask)
  );

  dlc_fifo #(.payload_t(sample_t)) u_in_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (in_push_i),
    .data_i  (in_data_i),
    .pop_i   (sample_pop),
    .data_o  (sample),
    .full_o  (in_full_o),
    .empty_o (sample_empty)
  );

  dlc_encoder u_encoder (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .sample_i        (sample),
    .sample_empty_i  (sample_empty),
    .sample_pop_o    (sample_pop),
    .pkt_full_i      (pkt_full),
    .pkt_push_o      (pkt_push),
    .pkt_o           (pkt),
    .cfg_log_wl_i    (cfg_log_wl),
    .cfg_dlvl_bits_i (cfg_dlvl_bits),
    .cfg_twos_comp_i (cfg_twos_comp),
    .cfg_dt_mask_i   (cfg_dt_mask)
  );

  dlc_fifo #(.payload_t(packet_t)) u_out_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (pkt_push),
    .data_i  (pkt),
    .pop_i   (out_pop_i),
    .data_o  (out_data_o),
    .full_o  (pkt_full),
    .empty_o (out_empty_o)
  );

endmodule

// File: testbench/tb_dlc.sv
/*
  Self-checking testbench for the level-crossing encoder top level.
  Replays register writes and samples from the golden file and pops packets at random.
*/
`timescale 1ns/1ps

module tb_dlc
  import dlc_cfg_pkg::*;
  import dlc_data_pkg::*;
();

  logic                  clk;
  logic                  rst_n;
  logic                  reg_valid;
  logic                  reg_wr;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [REG_DATA_W-1:0] reg_wdata;
  logic [REG_DATA_W-1:0] reg_rdata;
  logic                  in_push;
  sample_t               in_data;
  logic                  in_full;
  logic                  out_pop;
  packet_t               out_data;
  logic                  out_empty;

  logic [7:0]  rec_kind[$];      // W, S or P per golden record
  logic [15:0] rec_a[$];         // Address, sample or packet
  logic [15:0] rec_b[$];         // Write data of W records
  packet_t     exp_q[$];         // Expected packets in order
  logic [15:0] shadow [4];       // Expected register contents
  int          popped = 0;       // Packets taken from the DUT
  logic        loaded = 1'b0;

  dlc_top dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .reg_valid_i (reg_valid),
    .reg_write_i (reg_wr),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .in_push_i   (in_push),
    .in_data_i   (in_data),
    .in_full_o   (in_full),
    .out_pop_i   (out_pop),
    .out_data_o  (out_data),
    .out_empty_o (out_empty)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Bits that each register keeps
  function automatic logic [15:0] field_mask(input logic [REG_ADDR_W-1:0] addr);
    case (addr)
      ADDR_LOG_WL, ADDR_DLVL_BITS: return 16'h000F;
      ADDR_DLVL_FMT:               return 16'h0001;
      default:                     return 16'hFFFF;
    endcase
  endfunction

  task automatic load_golden();
    int          fd;
    int          ch;
    int          n;
    logic [7:0]  kind;
    logic [15:0] a;
    logic [15:0] b;
    fd = $fopen("testbench/dlc_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden data file testbench/dlc_golden.txt");
      $display("TB FAILED");
      $fatal(1, "missing golden file");
    end
    ch = $fgetc(fd);
    while (ch != -1) begin
      kind = 8'(ch);
      b    = '0;
      n    = 1;
      if (kind == "#") begin  // Comment runs to end of line
        while (ch != -1 && 8'(ch) != "\n") begin
          ch = $fgetc(fd);
        end
      end else if (kind == "W") begin
        n = ($fscanf(fd, "%h %h", a, b) == 2) ? 1 : 0;
      end else if (kind == "S" || kind == "P") begin
        n = ($fscanf(fd, "%h", a) == 1) ? 1 : 0;
      end else if (kind != " " && kind != "\n" && kind != "\r" && kind != "\t") begin
        n = 0;
      end
      if (n == 0) begin
        $display("Malformed record in golden data file near kind %c", kind);
        $display("TB FAILED");
        $fatal(1, "bad golden file");
      end
      if (kind == "W" || kind == "S" || kind == "P") begin
        rec_kind.push_back(kind);
        rec_a.push_back(a);
        rec_b.push_back(b);
        if (kind == "P") exp_q.push_back(packet_t'(a));
      end
      if (ch != -1) ch = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // Called a little after a rising edge and returns one cycle later
  task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [15:0] data);
    reg_valid = 1'b1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #1;
    reg_valid = 1'b0;
    reg_wr    = 1'b0;
  endtask

  task automatic read_check(input logic [REG_ADDR_W-1:0] addr, input logic [15:0] exp);
    reg_valid = 1'b1;
    reg_addr  = addr;
    #2;  // Combinational read path
    check($sformatf("reg_rdata_o[%0d]", addr), reg_rdata, exp);
    reg_valid = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic check_regs();
    for (int k = 0; k < 16; k++) begin
      read_check(REG_ADDR_W'(k), (k < 4) ? shadow[k[1:0]] : 16'h0000);  // Unmapped read zero
    end
  endtask

  task automatic push_sample(input logic [15:0] s);
    while (in_full) begin  // Source holds off while full
      @(posedge clk);
      #1;
    end
    in_push = 1'b1;
    in_data = sample_t'(s);
    @(posedge clk);
    #1;
    in_push = 1'b0;
  endtask

  task automatic wait_popped(input int target);
    while (popped < target) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Sink with random pops for back-pressure
  initial begin : pop_proc
    logic [31:0] lfsr;
    lfsr    = 32'h9077d215;
    out_pop = 1'b0;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      #1;
      out_pop = 1'b0;
      if (!out_empty) begin
        lfsr = lfsr_next(lfsr);
        if (lfsr[0] && exp_q.size() == 0) begin
          $display("DUT produced a packet %h with no expected packet left", out_data);
          $display("TB FAILED");
          $fatal(1, "extra packet");
        end else if (lfsr[0]) begin
          check("out_data_o", out_data, exp_q.pop_front());
          popped++;
          out_pop = 1'b1;  // Taken at next edge
        end
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (200 * (rec_kind.size() + 1)) @(posedge clk);
    $display("Timeout: the output stalled with %0d packets still expected", exp_q.size());
    $display("TB FAILED");
    $fatal(1, "watchdog timeout");
  end

  initial begin : main_proc
    int                    p_seen;
    int                    waited;
    logic [REG_ADDR_W-1:0] addr;
    rst_n     = 1'b0;
    reg_valid = 1'b0;
    reg_wr    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    in_push   = 1'b0;
    in_data   = '0;
    shadow[0] = 16'h0000;  // Register reset values
    shadow[1] = 16'h0004;
    shadow[2] = 16'h0000;
    shadow[3] = 16'h00FF;
    p_seen    = 0;
    waited    = 0;
    load_golden();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check("in_full_o", 16'(in_full), 16'h0000);  // FIFO flags idle after reset
    check("out_empty_o", 16'(out_empty), 16'h0001);
    check_regs();
    foreach (rec_kind[i]) begin
      case (rec_kind[i])
        "W": begin
          wait_popped(p_seen);  // Encoder drained before a config change
          addr = rec_a[i][REG_ADDR_W-1:0];
          write_reg(addr, rec_b[i]);
          if (addr[REG_ADDR_W-1:2] == '0) shadow[addr[1:0]] = rec_b[i] & field_mask(addr);
          read_check(addr, (addr[REG_ADDR_W-1:2] == '0) ? shadow[addr[1:0]] : 16'h0000);
        end
        "S": push_sample(rec_a[i]);
        default: p_seen++;
      endcase
    end
    // Last packets get a bounded drain time
    while (popped < p_seen && waited < 200) begin
      @(posedge clk);
      #1;
      waited++;
    end
    repeat (20) @(posedge clk);  // Window for stray packets
    #1;
    check("out_empty_o", 16'(out_empty), 16'h0001);
    check("in_full_o", 16'(in_full), 16'h0000);
    check_regs();
    if (exp_q.size() != 0) begin
      $display("Run ended with %0d expected packets never seen", exp_q.size());
      $display("TB FAILED");
      $fatal(1, "missing packets");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// File: testbench/dlc_golden.txt
# Records: W <addr> <data> register write, S <sample> input sample, P <packet> expected packet
# All fields hex; samples are 16-bit two's complement
W 0 0002
W 1 0004
S 0008
P 0002
S 0009
S 0004
P 0051
S FFF0
P 0035
W 2 0001
S FFE8
P 001E
S FFEA
S 0000
P 0026
S 0080
P 001F
P 000F
P 0002
S 0084
P 0011
W 2 0000
W 1 0003
S 0034
P 001F
P 000F
P 000E
S 0038
P 0011
W 3 0003
S 0039
S 003A
S 003B
P 0030
S 0040
P 0012

// File: src.f
source/dlc_cfg_pkg.sv
source/dlc_data_pkg.sv
source/dlc_fifo.sv
source/dlc_regs.sv
source/dlc_encoder.sv
source/dlc_top.sv
testbench/tb_dlc.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the level-crossing encoder testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --timing -f src.f --top-module tb_dlc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_dlc)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
